// ==== verilog.f ====
verilog/copro_pkg.sv
verilog/copro_fifo.sv
verilog/copro_decode.sv
verilog/copro_execute.sv
verilog/copro_result.sv
verilog/copro_top.sv
dv/copro_tb.sv

// ==== Bender.yml ====
package:
  name: copro

sources:
  - files:
      - verilog/copro_pkg.sv
      - verilog/copro_fifo.sv
      - verilog/copro_decode.sv
      - verilog/copro_execute.sv
      - verilog/copro_result.sv
      - verilog/copro_top.sv
  - target: test
    files:
      - dv/copro_tb.sv

// ==== dv/copro_tb.sv ====
// Runs XLEN 32, ID_WIDTH 4, DEPTH 4 only; expected results come from a local model in issue order
`timescale 1ns/1ps

module copro_tb;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned ID_WIDTH      = 4;
  localparam int unsigned DEPTH         = 4;
  localparam int unsigned CLK_PERIOD    = 8;
  localparam int unsigned ISSUE_TIMEOUT = 500;
  localparam int unsigned DRAIN_TIMEOUT = 2000;
  localparam longint      SMAX_L        = (longint'(1) <<< (XLEN - 1)) - 1;
  localparam longint      SMIN_L        = -(longint'(1) <<< (XLEN - 1));

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [XLEN-1:0]     data;
    logic [4:0]          rd;
    logic                we;
    logic                exc;
    logic [5:0]          exccode;
  } exp_result_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                issue_valid_i;
  logic [31:0]         issue_instr_i;
  logic [XLEN-1:0]     issue_rs1_i;
  logic [XLEN-1:0]     issue_rs2_i;
  logic [ID_WIDTH-1:0] issue_id_i;
  logic                issue_ready_o;
  logic                issue_accept_o;
  logic                issue_writeback_o;
  logic                result_valid_o;
  logic [ID_WIDTH-1:0] result_id_o;
  logic [XLEN-1:0]     result_data_o;
  logic [4:0]          result_rd_o;
  logic                result_we_o;
  logic                result_exc_o;
  logic [5:0]          result_exccode_o;
  logic                result_ready_i;

  exp_result_t         model_q[$];
  int unsigned         issue_errs = 0;
  int unsigned         result_errs = 0;
  int unsigned         flag_errs = 0;
  int unsigned         timeouts = 0;
  int unsigned         results_checked = 0;
  bit                  bp_mode = 1'b0;
  logic [ID_WIDTH-1:0] next_id = '0;

  copro_top #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH), .DEPTH(DEPTH)) i_copro_top (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_id_i        (issue_id_i),
    .issue_ready_o     (issue_ready_o),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .result_valid_o    (result_valid_o),
    .result_id_o       (result_id_o),
    .result_data_o     (result_data_o),
    .result_rd_o       (result_rd_o),
    .result_we_o       (result_we_o),
    .result_exc_o      (result_exc_o),
    .result_exccode_o  (result_exccode_o),
    .result_ready_i    (result_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic longint clamp(input longint v);
    if (v > SMAX_L) return SMAX_L;
    if (v < SMIN_L) return SMIN_L;
    return v;
  endfunction

  // Reference model, worked out in wide signed arithmetic
  function automatic exp_result_t expect_result(input copro_pkg::copro_op_e op,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [4:0] rd,
      input logic [ID_WIDTH-1:0] id);
    exp_result_t e;
    longint      sa;
    longint      sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    e.id = id;
    e.rd = rd;
    e.data = '0;
    e.we = 1'b1;
    e.exc = 1'b0;
    e.exccode = 6'd0;
    case (op)
      copro_pkg::SADD_SAT: e.data = XLEN'(clamp(sa + sb));
      copro_pkg::SSUB_SAT: e.data = XLEN'(clamp(sa - sb));
      copro_pkg::POPCNT:   e.data = XLEN'($countones(a));
      copro_pkg::BREV: begin
        for (int k = 0; k < XLEN / 8; k++) begin
          e.data[8*k +: 8] = a[XLEN-1-8*k -: 8];
        end
      end
      copro_pkg::ABSDIFF:  e.data = XLEN'((sa >= sb) ? sa - sb : sb - sa);
      copro_pkg::ADD_CHK: begin
        if (clamp(sa + sb) != sa + sb) begin
          e.we = 1'b0;
          e.exc = 1'b1;
          e.exccode = copro_pkg::EXC_OVERFLOW;
        end else begin
          e.data = XLEN'(sa + sb);
        end
      end
      default: e.we = 1'b1;
    endcase
    return e;
  endfunction

  function automatic logic is_legal(input logic [31:0] instr);
    return (instr[6:0] == copro_pkg::OPCODE_CUSTOM0) && (instr[31:25] == 7'd0) &&
           (instr[14:12] <= 3'd5);
  endfunction

  // Half of the operands sit on or next to the signed limits
  function automatic logic [XLEN-1:0] rand_operand();
    case ($urandom_range(0, 7))
      0: return {1'b0, {(XLEN-1){1'b1}}};
      1: return {1'b1, {(XLEN-1){1'b0}}};
      2: return '0;
      3: return '1;
      4: return {1'b0, {(XLEN-1){1'b1}}} - XLEN'($urandom_range(1, 3));
      5: return {1'b1, {(XLEN-1){1'b0}}} + XLEN'($urandom_range(1, 3));
      default: return XLEN'($urandom);
    endcase
  endfunction

  function automatic logic [31:0] make_instr(input logic [6:0] funct7, input logic [2:0] funct3,
      input logic [6:0] opcode);
    return {funct7, 5'($urandom), 5'($urandom), funct3, 5'($urandom), opcode};
  endfunction

  // One of the three ways to miss decode, picked at random
  function automatic logic [31:0] illegal_instr();
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    opc = copro_pkg::OPCODE_CUSTOM0;
    f7 = 7'd0;
    f3 = 3'($urandom_range(0, 5));
    case ($urandom_range(0, 2))
      0: opc = copro_pkg::OPCODE_CUSTOM0 ^ 7'($urandom_range(1, 127));
      1: f7 = 7'($urandom_range(1, 127));
      default: f3 = 3'($urandom_range(6, 7));
    endcase
    return make_instr(f7, f3, opc);
  endfunction

  task automatic check_issue_resp(input logic got_acc, input logic got_wb, input logic exp_acc);
    if (got_acc !== exp_acc || got_wb !== exp_acc) begin
      issue_errs++;
      $display("** Error at %0t: issue accept %b writeback %b, expected both %b",
               $time, got_acc, got_wb, exp_acc);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input logic [ID_WIDTH-1:0] id, input logic [XLEN-1:0] data,
      input logic [4:0] rd, input logic we, input logic exc, input logic [5:0] exccode,
      input exp_result_t e);
    if ({id, data, rd, we, exc, exccode} !== e) begin
      result_errs++;
      $display("** Error at %0t: result id %0d rd %0d data %h we %b exc %b code %0d",
               $time, id, rd, data, we, exc, exccode);
      $display("   expected id %0d rd %0d data %h we %b exc %b code %0d",
               e.id, e.rd, e.data, e.we, e.exc, e.exccode);
    end
  endtask

  // Offers one instruction and holds it until the decode queue has room
  task automatic send_instr(input logic [31:0] instr, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i = a;
    issue_rs2_i = b;
    issue_id_i = next_id;
    #1;
    check_issue_resp(issue_accept_o, issue_writeback_o, is_legal(instr));
    while (!issue_ready_o && waited < ISSUE_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!issue_ready_o) begin
      timeouts++;
      $display("Timeout: issue_ready_o stayed low for %0d cycles", waited);
    end else begin
      if (is_legal(instr)) begin
        model_q.push_back(expect_result(copro_pkg::copro_op_e'(instr[14:12]), a, b,
                                        instr[11:7], next_id));
      end
      next_id++;
    end
  endtask

  task automatic idle();
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic drain_results();
    int unsigned waited;
    waited = 0;
    idle();
    #1;
    bp_mode = 1'b0;
    while (model_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (model_q.size() != 0) begin
      timeouts++;
      $display("Timeout: %0d results still missing after %0d cycles", model_q.size(), waited);
    end
  endtask

  // Drives result_ready_i and checks each result on the edge before it is taken
  initial begin : result_monitor
    logic        ready;
    int unsigned hold;
    ready = 1'b1;
    hold = 0;
    result_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (!bp_mode) begin
        ready = ($urandom_range(0, 7) != 0);
      end else if (hold == 0) begin
        ready = !ready;
        hold = ready ? $urandom_range(1, 6) : $urandom_range(5, 30);
      end else begin
        hold--;
      end
      result_ready_i = ready;
      if (result_valid_o && ready) begin
        if (model_q.size() == 0) begin
          result_errs++;
          $display("Result with id %0d arrived while nothing was outstanding", result_id_o);
        end else begin
          check_result(result_id_o, result_data_o, result_rd_o, result_we_o, result_exc_o,
                       result_exccode_o, model_q.pop_front());
          results_checked++;
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] chk;
    void'($urandom(89));
    arst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    issue_id_i = '0;
    chk = make_instr(7'd0, 3'(copro_pkg::ADD_CHK), copro_pkg::OPCODE_CUSTOM0);
    repeat (4) begin
      @(negedge clk_i);
      check_flag("result_valid_o in reset", result_valid_o, 1'b0);
      check_flag("issue_ready_o in reset", issue_ready_o, 1'b1);
    end
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("result_valid_o after reset", result_valid_o, 1'b0);
    check_flag("issue_ready_o after reset", issue_ready_o, 1'b1);
    check_flag("issue_accept_o without valid", issue_accept_o, 1'b0);
    for (int i = 0; i < 200 && timeouts == 0; i++) begin
      send_instr(make_instr(7'd0, 3'($urandom_range(0, 5)), copro_pkg::OPCODE_CUSTOM0),
                 rand_operand(), rand_operand());
      if ($urandom_range(0, 3) == 0) idle();
    end
    for (int i = 0; i < 80 && timeouts == 0; i++) begin
      send_instr(($urandom_range(0, 1) == 0) ? illegal_instr() :
                 make_instr(7'd0, 3'($urandom_range(0, 5)), copro_pkg::OPCODE_CUSTOM0),
                 rand_operand(), rand_operand());
    end
    // Checked add on both sides of the overflow boundary
    send_instr(chk, 32'h7fff_ffff, 32'h0000_0001);
    send_instr(chk, 32'h8000_0000, 32'hffff_ffff);
    send_instr(chk, 32'h8000_0000, 32'h8000_0000);
    send_instr(chk, 32'hffff_ffff, 32'h0000_0001);
    send_instr(chk, 32'h7fff_ffff, 32'h8000_0000);
    for (int i = 0; i < 40 && timeouts == 0; i++) begin
      send_instr(chk, rand_operand(), rand_operand());
    end
    bp_mode = 1'b1;
    for (int i = 0; i < 150 && timeouts == 0; i++) begin
      send_instr(($urandom_range(0, 3) == 0) ? illegal_instr() :
                 make_instr(7'd0, 3'($urandom_range(0, 5)), copro_pkg::OPCODE_CUSTOM0),
                 rand_operand(), rand_operand());
    end
    if (timeouts == 0) drain_results();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_flag("result_valid_o once drained", result_valid_o, 1'b0);
    end
    $display("Summary: %0d issue, %0d result, %0d flag errors, %0d timeouts, %0d results checked",
             issue_errs, result_errs, flag_errs, timeouts, results_checked);
    if (issue_errs + result_errs + flag_errs + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/copro_top.sv ====
// Coprocessor top; only issue and result channels, no hazard tracking, 2*DEPTH instructions in flight
`timescale 1ns/1ps

module copro_top #(
  parameter int unsigned XLEN     = 32,
  parameter int unsigned ID_WIDTH = 4,
  parameter int unsigned DEPTH    = 4
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                issue_valid_i,
  input  logic [31:0]         issue_instr_i,
  input  logic [XLEN-1:0]     issue_rs1_i,
  input  logic [XLEN-1:0]     issue_rs2_i,
  input  logic [ID_WIDTH-1:0] issue_id_i,
  output logic                issue_ready_o,
  output logic                issue_accept_o,
  output logic                issue_writeback_o,
  output logic                result_valid_o,
  output logic [ID_WIDTH-1:0] result_id_o,
  output logic [XLEN-1:0]     result_data_o,
  output logic [4:0]          result_rd_o,
  output logic                result_we_o,
  output logic                result_exc_o,
  output logic [5:0]          result_exccode_o,
  input  logic                result_ready_i
);

  typedef struct packed {
    copro_pkg::copro_op_e op;
    logic [XLEN-1:0]      rs1;
    logic [XLEN-1:0]      rs2;
    logic [4:0]           rd;
    logic [ID_WIDTH-1:0]  id;
  } dec_entry_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [XLEN-1:0]     data;
    logic [4:0]          rd;
    logic                we;
    logic                exc;
    logic [5:0]          exccode;
  } res_entry_t;

  // Entries are assembled field by field from the stage outputs
  wire dec_entry_t dec_in;
  wire dec_entry_t dec_head;
  wire res_entry_t res_in;
  wire res_entry_t res_head;
  wire             dec_push;
  wire             dec_full;
  wire             dec_pop;
  wire             dec_valid;
  wire             res_push;
  wire             res_full;
  wire             res_pop;
  wire             res_valid;

  copro_decode #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_copro_decode (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_id_i        (issue_id_i),
    .fifo_full_i       (dec_full),
    .issue_ready_o     (issue_ready_o),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .dec_push_o        (dec_push),
    .dec_op_o          (dec_in.op),
    .dec_rs1_o         (dec_in.rs1),
    .dec_rs2_o         (dec_in.rs2),
    .dec_rd_o          (dec_in.rd),
    .dec_id_o          (dec_in.id)
  );

  copro_fifo #(.T_ENTRY(dec_entry_t), .DEPTH(DEPTH)) i_dec_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (dec_push),
    .data_i   (dec_in),
    .full_o   (dec_full),
    .pop_i    (dec_pop),
    .data_o   (dec_head),
    .valid_o  (dec_valid)
  );

  copro_execute #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_copro_execute (
    .dec_valid_i   (dec_valid),
    .dec_op_i      (dec_head.op),
    .dec_rs1_i     (dec_head.rs1),
    .dec_rs2_i     (dec_head.rs2),
    .dec_rd_i      (dec_head.rd),
    .dec_id_i      (dec_head.id),
    .res_full_i    (res_full),
    .dec_pop_o     (dec_pop),
    .res_push_o    (res_push),
    .res_id_o      (res_in.id),
    .res_data_o    (res_in.data),
    .res_rd_o      (res_in.rd),
    .res_we_o      (res_in.we),
    .res_exc_o     (res_in.exc),
    .res_exccode_o (res_in.exccode)
  );

  copro_fifo #(.T_ENTRY(res_entry_t), .DEPTH(DEPTH)) i_res_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (res_push),
    .data_i   (res_in),
    .full_o   (res_full),
    .pop_i    (res_pop),
    .data_o   (res_head),
    .valid_o  (res_valid)
  );

  copro_result #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_copro_result (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .q_valid_i        (res_valid),
    .q_id_i           (res_head.id),
    .q_data_i         (res_head.data),
    .q_rd_i           (res_head.rd),
    .q_we_i           (res_head.we),
    .q_exc_i          (res_head.exc),
    .q_exccode_i      (res_head.exccode),
    .result_ready_i   (result_ready_i),
    .q_pop_o          (res_pop),
    .result_valid_o   (result_valid_o),
    .result_id_o      (result_id_o),
    .result_data_o    (result_data_o),
    .result_rd_o      (result_rd_o),
    .result_we_o      (result_we_o),
    .result_exc_o     (result_exc_o),
    .result_exccode_o (result_exccode_o)
  );

endmodule

// ==== verilog/copro_result.sv ====
// Result channel driver; the head of the result queue is the payload and leaves on valid and ready
`timescale 1ns/1ps

module copro_result #(
  parameter int unsigned XLEN     = 32,
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                q_valid_i,
  input  logic [ID_WIDTH-1:0] q_id_i,
  input  logic [XLEN-1:0]     q_data_i,
  input  logic [4:0]          q_rd_i,
  input  logic                q_we_i,
  input  logic                q_exc_i,
  input  logic [5:0]          q_exccode_i,
  input  logic                result_ready_i,
  output logic                q_pop_o,
  output logic                result_valid_o,
  output logic [ID_WIDTH-1:0] result_id_o,
  output logic [XLEN-1:0]     result_data_o,
  output logic [4:0]          result_rd_o,
  output logic                result_we_o,
  output logic                result_exc_o,
  output logic [5:0]          result_exccode_o
);

  logic xfer;

  assign result_valid_o   = q_valid_i;
  assign result_id_o      = q_id_i;
  assign result_data_o    = q_data_i;
  assign result_rd_o      = q_rd_i;
  assign result_we_o      = q_we_i;
  assign result_exc_o     = q_exc_i;
  assign result_exccode_o = q_exccode_i;

  assign xfer    = q_valid_i && result_ready_i;
  assign q_pop_o = xfer;

  a_payload_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (result_valid_o && !result_ready_i) |=>
      (result_valid_o && $stable({result_id_o, result_data_o, result_rd_o,
                                  result_we_o, result_exc_o, result_exccode_o})));

endmodule

// ==== verilog/copro_execute.sv ====
// Single-cycle execute between the queues; XLEN must be a multiple of 8 for the byte reverse
`timescale 1ns/1ps

module copro_execute #(
  parameter int unsigned XLEN     = 32,
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                 dec_valid_i,
  input  copro_pkg::copro_op_e dec_op_i,
  input  logic [XLEN-1:0]      dec_rs1_i,
  input  logic [XLEN-1:0]      dec_rs2_i,
  input  logic [4:0]           dec_rd_i,
  input  logic [ID_WIDTH-1:0]  dec_id_i,
  input  logic                 res_full_i,
  output logic                 dec_pop_o,
  output logic                 res_push_o,
  output logic [ID_WIDTH-1:0]  res_id_o,
  output logic [XLEN-1:0]      res_data_o,
  output logic [4:0]           res_rd_o,
  output logic                 res_we_o,
  output logic                 res_exc_o,
  output logic [5:0]           res_exccode_o
);

  localparam logic [XLEN-1:0] SMAX = {1'b0, {(XLEN-1){1'b1}}};
  localparam logic [XLEN-1:0] SMIN = {1'b1, {(XLEN-1){1'b0}}};

  function automatic logic [XLEN-1:0] popcnt(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < XLEN; i++) begin
      cnt = cnt + XLEN'(v[i]);
    end
    return cnt;
  endfunction

  function automatic logic [XLEN-1:0] brev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    r = '0;
    for (int b = 0; b < XLEN / 8; b++) begin
      r[8*b +: 8] = v[XLEN-8-8*b +: 8];
    end
    return r;
  endfunction

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            add_ovf;
  logic            sub_ovf;

  assign sum  = dec_rs1_i + dec_rs2_i;
  assign diff = dec_rs1_i - dec_rs2_i;

  // Overflow from the operand and result signs
  assign add_ovf = (dec_rs1_i[XLEN-1] == dec_rs2_i[XLEN-1]) &&
                   (sum[XLEN-1] != dec_rs1_i[XLEN-1]);
  assign sub_ovf = (dec_rs1_i[XLEN-1] != dec_rs2_i[XLEN-1]) &&
                   (diff[XLEN-1] != dec_rs1_i[XLEN-1]);

  // The head moves only when there is room downstream
  assign dec_pop_o  = dec_valid_i && !res_full_i;
  assign res_push_o = dec_pop_o;
  assign res_id_o   = dec_id_i;
  assign res_rd_o   = dec_rd_i;

  always_comb begin
    res_data_o = '0;
    res_exc_o  = 1'b0;
    unique case (dec_op_i)
      copro_pkg::SADD_SAT: res_data_o = add_ovf ? (dec_rs1_i[XLEN-1] ? SMIN : SMAX) : sum;
      copro_pkg::SSUB_SAT: res_data_o = sub_ovf ? (dec_rs1_i[XLEN-1] ? SMIN : SMAX) : diff;
      copro_pkg::POPCNT:   res_data_o = popcnt(dec_rs1_i);
      copro_pkg::BREV:     res_data_o = brev(dec_rs1_i);
      copro_pkg::ABSDIFF: begin
        res_data_o = ($signed(dec_rs1_i) >= $signed(dec_rs2_i)) ? diff : dec_rs2_i - dec_rs1_i;
      end
      copro_pkg::ADD_CHK: begin
        // A trapping add writes nothing back
        res_exc_o  = add_ovf;
        res_data_o = add_ovf ? '0 : sum;
      end
      default: res_data_o = '0;
    endcase
  end

  assign res_we_o      = !res_exc_o;
  assign res_exccode_o = res_exc_o ? copro_pkg::EXC_OVERFLOW : 6'd0;

endmodule

// ==== verilog/copro_decode.sv ====
// Issue stage decode; accept and writeback are combinational and follow valid, core holds inputs on stall
`timescale 1ns/1ps

module copro_decode #(
  parameter int unsigned XLEN     = 32,
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 issue_valid_i,
  input  logic [31:0]          issue_instr_i,
  input  logic [XLEN-1:0]      issue_rs1_i,
  input  logic [XLEN-1:0]      issue_rs2_i,
  input  logic [ID_WIDTH-1:0]  issue_id_i,
  input  logic                 fifo_full_i,
  output logic                 issue_ready_o,
  output logic                 issue_accept_o,
  output logic                 issue_writeback_o,
  output logic                 dec_push_o,
  output copro_pkg::copro_op_e dec_op_o,
  output logic [XLEN-1:0]      dec_rs1_o,
  output logic [XLEN-1:0]      dec_rs2_o,
  output logic [4:0]           dec_rd_o,
  output logic [ID_WIDTH-1:0]  dec_id_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  // R-type field positions
  assign opcode = issue_instr_i[6:0];
  assign rd     = issue_instr_i[11:7];
  assign funct3 = issue_instr_i[14:12];
  assign funct7 = issue_instr_i[31:25];

  assign legal = (opcode == copro_pkg::OPCODE_CUSTOM0) &&
                 (funct7 == copro_pkg::FUNCT7_COPRO) &&
                 (funct3 <= copro_pkg::FUNCT3_LAST);

  // A rejected instruction still handshakes, it just never reaches the queue
  assign issue_ready_o     = !fifo_full_i;
  assign issue_accept_o    = issue_valid_i && legal;
  assign issue_writeback_o = issue_accept_o;

  assign dec_push_o = issue_valid_i && issue_ready_o && legal;
  assign dec_op_o   = copro_pkg::copro_op_e'(funct3);
  assign dec_rs1_o  = issue_rs1_i;
  assign dec_rs2_o  = issue_rs2_i;
  assign dec_rd_o   = rd;
  assign dec_id_o   = issue_id_i;

  // Once offered the instruction may not be withdrawn or changed before it is taken
  a_issue_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (issue_valid_i && !issue_ready_o) |=>
      (issue_valid_i && $stable(issue_instr_i) && $stable(issue_rs1_i) &&
       $stable(issue_rs2_i) && $stable(issue_id_i)));

endmodule

// ==== verilog/copro_fifo.sv ====
// Queue without fall-through: a pushed entry shows on data_o from the next cycle; push on full is dropped
`timescale 1ns/1ps

module copro_fifo #(
  parameter type         T_ENTRY = logic,
  parameter int unsigned DEPTH   = 4
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   push_i,
  input  T_ENTRY data_i,
  output logic   full_o,
  input  logic   pop_i,
  output T_ENTRY data_o,
  output logic   valid_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T_ENTRY             mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push_en;
  logic               pop_en;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && valid_o;

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The producer must look at full_o and the consumer at valid_o
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o);
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> valid_o);

endmodule

// ==== verilog/copro_pkg.sv ====
// Shared encodings for the coprocessor; operations map one to one onto funct3 0..5 of custom-0
package copro_pkg;

  // Operation codes, listed in the same order as their funct3 values
  typedef enum logic [2:0] {
    SADD_SAT = 3'd0,
    SSUB_SAT = 3'd1,
    POPCNT   = 3'd2,
    BREV     = 3'd3,
    ABSDIFF  = 3'd4,
    ADD_CHK  = 3'd5
  } copro_op_e;

  // Major opcode of the custom-0 space in the base RISC-V map
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // Only funct7 of zero is offloaded here
  localparam logic [6:0] FUNCT7_COPRO = 7'b0000000;

  // Highest funct3 value that names a valid operation
  localparam logic [2:0] FUNCT3_LAST = 3'd5;

  // Exception code for a checked add that overflows
  // Taken from the range the privileged spec reserves for custom use
  localparam logic [5:0] EXC_OVERFLOW = 6'd24;

endpackage
